// ==== flist.f ====
rvIsaPkg.sv
coreCfgPkg.sv
regFile.sv
decoder.sv
alu.sv
fetchUnit.sv
execUnit.sv
memArbiter.sv
sharedMem.sv
riscvTop.sv
riscvTb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - rvIsaPkg.sv
  - coreCfgPkg.sv
  - regFile.sv
  - decoder.sv
  - alu.sv
  - fetchUnit.sv
  - execUnit.sv
  - memArbiter.sv
  - sharedMem.sv
  - riscvTop.sv
  - target: simulation
    files:
      - riscvTb.sv

// ==== riscvTb.sv ====
/*
 * Directed testbench for the three-stage RV32I core. Programs and
 * operands go in, and results come out, through the loader port
 */
`timescale 1ns/100ps

module riscvTb import rvIsaPkg::*, coreCfgPkg::*; ();

   localparam int          CLK_PERIOD  = 8;
   localparam logic [31:0] SEED        = 32'h2cdd5565;
   // Word addresses of the memory regions
   localparam int          DATA_W      = 256;
   localparam int          RUNSUM_W    = 320;
   localparam int          SCRATCH_B   = 32'h580;
   localparam int          RES_W       = 384;
   localparam int          DONE_W      = 511;
   localparam int          LOOPBACK_W  = 768;
   localparam int          FILL_WORDS  = 96;
   localparam int          LOOP_LEN    = 16;
   localparam int          POLL_CYCLES = 24;
   localparam int          POLL_LIMIT  = 60;
   localparam int          PROGRAMS    = 7;
   localparam int          RUN_CYCLES  = POLL_LIMIT * (POLL_CYCLES + 4);
   localparam int          WATCHDOG_CYCLES = PROGRAMS * (RUN_CYCLES + 400) + 200;

   logic        clk;
   logic        rst;
   logic        run;
   memReqS      extReq;
   logic [31:0] extRdata;
   logic [31:0] lfsr;

   logic [31:0] prog [$];
   logic [31:0] expected [$];
   string       resultName [$];

   riscvTop i_dut (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .extReq   (extReq),
      .extRdata (extRdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] value;
      logic        fb;
      int          i;
      value = 32'd0;
      for (i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   // Instruction encoders, fields placed as in the RV32I spec
   function automatic logic [31:0] rInst(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
   endfunction

   function automatic logic [31:0] iInst(input int imm, input int rs1, input int f3,
                                         input int rd, input logic [6:0] op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] loadInst(input int rd, input int off, input int rs1);
      return iInst(off, rs1, 2, rd, OP_LOAD);
   endfunction

   function automatic logic [31:0] storeInst(input int rs2, input int off, input int rs1);
      return {off[11:5], rs2[4:0], rs1[4:0], 3'd2, off[4:0], OP_STORE};
   endfunction

   function automatic logic [31:0] branchInst(input int f3, input int rs1, input int rs2,
                                              input int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
              OP_BRANCH};
   endfunction

   function automatic logic [31:0] upperInst(input int imm, input int rd,
                                             input logic [6:0] op);
      return {imm[19:0], rd[4:0], op};
   endfunction

   function automatic logic [31:0] jalInst(input int rd, input int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
   endfunction

   // Reference semantics of the integer operations
   function automatic logic [31:0] aluModel(input int f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
      logic [31:0] r;
      case (f3)
         0: r = alt ? a - b : a + b;
         1: r = a << b[4:0];
         2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3: r = (a < b) ? 32'd1 : 32'd0;
         4: r = a ^ b;
         5:
         begin
            if (alt)
               r = $unsigned($signed(a) >>> b[4:0]);
            else
               r = a >> b[4:0];
         end
         6: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic branchModel(input int f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         0: return a == b;
         1: return a != b;
         4: return $signed(a) < $signed(b);
         5: return $signed(a) >= $signed(b);
         6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   function automatic logic [31:0] fillWord(input int w);
      return 32'hbad0_0000 | w[ADDR_W-1:0];
   endfunction

   task automatic failRun(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first failure");
   endtask

   task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         failRun($sformatf("Mismatch at %0t: %s got %08h expected %08h",
                           $time, name, got, exp));
   endtask

   task automatic memWrite(input int addr, input logic [31:0] data);
      extReq.req = 1'b1;
      extReq.we = 1'b1;
      extReq.addr = addr[ADDR_W-1:0];
      extReq.wdata = data;
      @(posedge clk);
      #1;
      extReq = '0;
   endtask

   // Data is due one cycle after the request
   task automatic memRead(input int addr, output logic [31:0] data);
      extReq.req = 1'b1;
      extReq.we = 1'b0;
      extReq.addr = addr[ADDR_W-1:0];
      extReq.wdata = 32'd0;
      @(posedge clk);
      #1;
      extReq = '0;
      data = extRdata;
   endtask

   task automatic resetCore();
      run = 1'b0;
      rst = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
   endtask

   task automatic beginProgram();
      prog.delete();
      expected.delete();
      resultName.delete();
   endtask

   // Results land in consecutive words from RES_W on
   task automatic storeResult(input int rs2, input string name, input logic [31:0] value);
      prog.push_back(storeInst(rs2, RES_W * 4 + 4 * expected.size(), 0));
      expected.push_back(value);
      resultName.push_back(name);
   endtask

   task automatic loadProgram();
      int i;
      prog.push_back(iInst(1, 0, 0, 31, OP_IMM));
      prog.push_back(storeInst(31, DONE_W * 4, 0));
      prog.push_back(jalInst(0, 0));
      for (i = 0; i < prog.size(); i++)
         memWrite(i, prog[i]);
      for (i = RUNSUM_W; i < RUNSUM_W + FILL_WORDS; i++)
         memWrite(i, fillWord(i));
      memWrite(DONE_W, 32'd0);
   endtask

   task automatic runProgram(input string title);
      logic [31:0] flag;
      int          polls;
      resetCore();
      flag = 32'd0;
      polls = 0;
      while (flag !== 32'd1)
      begin
         if (polls == POLL_LIMIT)
            failRun($sformatf("Program %s never stored its completion marker", title));
         polls++;
         run = 1'b1;
         repeat (POLL_CYCLES) @(posedge clk);
         #1;
         run = 1'b0;
         @(posedge clk);
         #1;
         memRead(DONE_W, flag);
      end
   endtask

   task automatic runAndCheck(input string title);
      logic [31:0] got;
      int          k;
      loadProgram();
      runProgram(title);
      for (k = 0; k < expected.size(); k++)
      begin
         memRead(RES_W + k, got);
         checkEq({title, " ", resultName[k]}, got, expected[k]);
      end
   endtask

   task automatic testLoaderPort();
      logic [31:0] words [16];
      logic [31:0] got;
      int          i;
      for (i = 0; i < 16; i++)
      begin
         words[i] = randBits(32);
         memWrite(LOOPBACK_W + i, words[i]);
      end
      for (i = 0; i < 16; i++)
      begin
         memRead(LOOPBACK_W + i, got);
         checkEq($sformatf("extRdata word %0d", LOOPBACK_W + i), got, words[i]);
      end
   endtask

   task automatic testAluOps(input int round);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] sh;
      int          f3;
      a = randBits(32);
      b = randBits(32);
      memWrite(DATA_W, a);
      memWrite(DATA_W + 1, b);
      beginProgram();
      prog.push_back(loadInst(1, DATA_W * 4, 0));
      prog.push_back(loadInst(2, DATA_W * 4 + 4, 0));
      for (f3 = 0; f3 < 8; f3++)
      begin
         prog.push_back(rInst(0, 2, 1, f3, 3));
         storeResult(3, $sformatf("reg funct3 %0d", f3), aluModel(f3, 1'b0, a, b));
      end
      prog.push_back(rInst(32, 2, 1, 0, 3));
      storeResult(3, "sub", aluModel(0, 1'b1, a, b));
      prog.push_back(rInst(32, 2, 1, 5, 3));
      storeResult(3, "sra", aluModel(5, 1'b1, a, b));
      for (f3 = 0; f3 < 8; f3++)
      begin
         if (f3 != 1 && f3 != 5)
         begin
            imm = randBits(12);
            prog.push_back(iInst(imm, 1, f3, 4, OP_IMM));
            imm = {{20{imm[11]}}, imm[11:0]};
            storeResult(4, $sformatf("imm funct3 %0d", f3), aluModel(f3, 1'b0, a, imm));
         end
      end
      sh = randBits(5);
      prog.push_back(iInst(sh, 1, 1, 4, OP_IMM));
      storeResult(4, "slli", aluModel(1, 1'b0, a, sh));
      prog.push_back(iInst(sh, 1, 5, 4, OP_IMM));
      storeResult(4, "srli", aluModel(5, 1'b0, a, sh));
      prog.push_back(iInst(1024 + sh, 1, 5, 4, OP_IMM));
      storeResult(4, "srai", aluModel(5, 1'b1, a, sh));
      runAndCheck($sformatf("alu round %0d", round));
   endtask

   task automatic testForwarding();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] x6;
      logic [31:0] x7;
      logic [31:0] x9;
      a = randBits(32);
      b = randBits(32);
      x6 = a + 32'd7;
      x7 = x6 + a;
      x9 = (x7 - x6) ^ x7;
      memWrite(DATA_W, a);
      memWrite(DATA_W + 1, b);
      beginProgram();
      prog.push_back(loadInst(5, DATA_W * 4, 0));
      prog.push_back(iInst(7, 5, 0, 6, OP_IMM));
      prog.push_back(rInst(0, 5, 6, 0, 7));
      prog.push_back(rInst(32, 6, 7, 0, 8));
      prog.push_back(rInst(0, 7, 8, 4, 9));
      prog.push_back(loadInst(10, DATA_W * 4 + 4, 0));
      prog.push_back(rInst(0, 9, 10, 0, 11));
      // Store then reload the same word
      prog.push_back(storeInst(9, SCRATCH_B, 0));
      prog.push_back(loadInst(12, SCRATCH_B, 0));
      prog.push_back(iInst(1, 12, 0, 13, OP_IMM));
      storeResult(6, "x6", x6);
      storeResult(7, "x7", x7);
      storeResult(8, "x8", x7 - x6);
      storeResult(9, "x9", x9);
      storeResult(11, "x11", b + x9);
      storeResult(13, "x13", x9 + 32'd1);
      runAndCheck("forwarding");
   endtask

   task automatic branchCase(input int f3, input int rs1, input int rs2,
                             input logic [31:0] x, input logic [31:0] y);
      prog.push_back(iInst(0, 0, 0, 21, OP_IMM));
      prog.push_back(branchInst(f3, rs1, rs2, 8));
      // Skipped when the branch is taken
      prog.push_back(iInst(1, 0, 0, 21, OP_IMM));
      storeResult(21, $sformatf("branch funct3 %0d x%0d x%0d", f3, rs1, rs2),
                  branchModel(f3, x, y) ? 32'd0 : 32'd1);
   endtask

   task automatic testBranches();
      logic [31:0] a;
      logic [31:0] b;
      int          f3;
      int          i;
      // Opposite signs make signed and unsigned compares disagree
      a = randBits(32) | 32'h8000_0000;
      b = randBits(32) & 32'h7fff_ffff;
      memWrite(DATA_W, a);
      memWrite(DATA_W + 1, b);
      beginProgram();
      prog.push_back(loadInst(1, DATA_W * 4, 0));
      prog.push_back(loadInst(2, DATA_W * 4 + 4, 0));
      prog.push_back(loadInst(3, DATA_W * 4, 0));
      for (f3 = 0; f3 < 8; f3++)
      begin
         if (f3 != 2 && f3 != 3)
         begin
            branchCase(f3, 1, 2, a, b);
            branchCase(f3, 2, 1, b, a);
            branchCase(f3, 1, 3, a, a);
         end
      end
      i = prog.size();
      prog.push_back(iInst(0, 0, 0, 23, OP_IMM));
      prog.push_back(jalInst(22, 8));
      prog.push_back(iInst(1, 0, 0, 23, OP_IMM));
      storeResult(22, "jal link", (i + 2) * 4);
      storeResult(23, "jal skipped", 32'd0);
      i = prog.size();
      prog.push_back(iInst((i + 3) * 4, 0, 0, 24, OP_IMM));
      // Odd offset, bit 0 of the target is dropped
      prog.push_back(iInst(1, 24, 0, 25, OP_JALR));
      prog.push_back(iInst(2, 0, 0, 23, OP_IMM));
      storeResult(25, "jalr link", (i + 2) * 4);
      storeResult(23, "jalr skipped", 32'd0);
      // A PC left odd by the jump would show up here
      i = prog.size();
      prog.push_back(upperInst(0, 26, OP_AUIPC));
      storeResult(26, "pc after jalr", i * 4);
      runAndCheck("branches");
   endtask

   task automatic testUpperImm();
      logic [31:0] hi;
      int          pc;
      int          i;
      beginProgram();
      for (i = 0; i < 2; i++)
      begin
         hi = randBits(20);
         prog.push_back(upperInst(hi, 5, OP_LUI));
         storeResult(5, "lui", {hi[19:0], 12'd0});
         hi = randBits(20);
         pc = prog.size() * 4;
         prog.push_back(upperInst(hi, 6, OP_AUIPC));
         storeResult(6, "auipc", pc + {hi[19:0], 12'd0});
      end
      runAndCheck("upper immediates");
   endtask

   task automatic testMixedLoop();
      logic [31:0] data [LOOP_LEN];
      logic [31:0] sums [LOOP_LEN];
      logic [31:0] total;
      logic [31:0] got;
      int          i;
      total = 32'd0;
      for (i = 0; i < LOOP_LEN; i++)
      begin
         data[i] = randBits(32);
         total = total + data[i];
         sums[i] = total;
         memWrite(DATA_W + i, data[i]);
      end
      beginProgram();
      prog.push_back(iInst(0, 0, 0, 1, OP_IMM));
      prog.push_back(iInst(LOOP_LEN, 0, 0, 2, OP_IMM));
      prog.push_back(iInst(0, 0, 0, 3, OP_IMM));
      prog.push_back(iInst(0, 0, 0, 4, OP_IMM));
      // Loop body, seven words
      prog.push_back(loadInst(5, DATA_W * 4, 1));
      prog.push_back(rInst(0, 5, 3, 0, 3));
      prog.push_back(storeInst(3, RUNSUM_W * 4, 1));
      prog.push_back(iInst(1, 4, 0, 4, OP_IMM));
      prog.push_back(iInst(4, 1, 0, 1, OP_IMM));
      prog.push_back(iInst(-1, 2, 0, 2, OP_IMM));
      prog.push_back(branchInst(1, 2, 0, -24));
      storeResult(3, "checksum", total);
      storeResult(4, "count", LOOP_LEN);
      runAndCheck("mixed loop");
      for (i = 0; i < LOOP_LEN; i++)
      begin
         memRead(RUNSUM_W + i, got);
         checkEq($sformatf("mixed loop running sum %0d", i), got, sums[i]);
      end
   endtask

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      run = 1'b0;
      extReq = '0;
      lfsr = SEED;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      testLoaderPort();
      testAluOps(0);
      testAluOps(1);
      testAluOps(2);
      testForwarding();
      testBranches();
      testUpperImm();
      testMixedLoop();
      $display("RESULT: PASS");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      failRun("Watchdog expired before all tests finished");
   end

endmodule

// ==== riscvTop.sv ====
/*
 * Three-stage RV32I core with one shared memory and an external loader port
 */
`timescale 1ns/100ps

module riscvTop import rvIsaPkg::*, coreCfgPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   input  memReqS      extReq,
   output logic [31:0] extRdata
);

   memReqS      fetchReq;
   memReqS      dataReq;
   memReqS      memReq;
   logic        fetchGnt;
   logic        dataGnt;
   logic [31:0] rdata;
   logic        instValid;
   instU        inst;
   logic [31:0] instPc;
   logic        redirect;
   logic [31:0] redirectPc;

   fetchUnit i_fetchUnit (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .fetchGnt   (fetchGnt),
      .rdata      (rdata),
      .fetchReq   (fetchReq),
      .instValid  (instValid),
      .inst       (inst),
      .instPc     (instPc)
   );

   execUnit i_execUnit (
      .clk        (clk),
      .rst        (rst),
      .instValid  (instValid),
      .inst       (inst),
      .instPc     (instPc),
      .dataGnt    (dataGnt),
      .rdata      (rdata),
      .dataReq    (dataReq),
      .redirect   (redirect),
      .redirectPc (redirectPc)
   );

   // Loader never waits, its grant is not needed outside
   memArbiter i_memArbiter (
      .extReq   (extReq),
      .dataReq  (dataReq),
      .fetchReq (fetchReq),
      .extGnt   (),
      .dataGnt  (dataGnt),
      .fetchGnt (fetchGnt),
      .memReq   (memReq)
   );

   sharedMem i_sharedMem (
      .clk    (clk),
      .memReq (memReq),
      .rdata  (rdata)
   );

   assign extRdata = rdata;

endmodule

// ==== sharedMem.sv ====
/*
 * Single-port word memory shared by code and data, one cycle read latency
 */
`timescale 1ns/100ps

module sharedMem import coreCfgPkg::*; (
   input  logic        clk,
   input  memReqS      memReq,
   output logic [31:0] rdata
);

   logic [31:0] mem [MEM_WORDS];

   always_ff @(posedge clk)
   begin
      if (memReq.req)
      begin
         if (memReq.we)
            mem[memReq.addr] <= memReq.wdata;
         else
            rdata <= mem[memReq.addr];
      end
   end

endmodule

// ==== memArbiter.sv ====
/*
 * Fixed-priority arbiter for the shared memory port.
 * Loader first, then data, then fetch
 */
`timescale 1ns/100ps

module memArbiter import coreCfgPkg::*; (
   input  memReqS extReq,
   input  memReqS dataReq,
   input  memReqS fetchReq,
   output logic   extGnt,
   output logic   dataGnt,
   output logic   fetchGnt,
   output memReqS memReq
);

   assign extGnt   = extReq.req;
   assign dataGnt  = dataReq.req && !extReq.req;
   assign fetchGnt = fetchReq.req && !extReq.req && !dataReq.req;

   always_comb
   begin
      if (extGnt)
         memReq = extReq;
      else if (dataGnt)
         memReq = dataReq;
      else if (fetchGnt)
         memReq = fetchReq;
      else
      begin
         // Idle port
         memReq = fetchReq;
         memReq.req = 1'b0;
         memReq.we = 1'b0;
      end
   end

endmodule

// ==== execUnit.sv ====
/*
 * Execute and writeback stages: operand forwarding, branch resolution,
 * load/store requests and register file update
 */
`timescale 1ns/100ps

module execUnit import rvIsaPkg::*, coreCfgPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        instValid,
   input  instU        inst,
   input  logic [31:0] instPc,
   input  logic        dataGnt,
   input  logic [31:0] rdata,
   output memReqS      dataReq,
   output logic        redirect,
   output logic [31:0] redirectPc
);

   instU        exInst;
   ctrlS        ctrl;
   logic [31:0] imm;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [31:0] rf1;
   logic [31:0] rf2;
   logic [31:0] rs1Val;
   logic [31:0] rs2Val;
   logic [31:0] opA;
   logic [31:0] opB;
   logic [31:0] aluResult;
   logic        branchTaken;
   wbRegS       wbReg;
   logic [31:0] wbValue;
   logic        wbWrite;

   // Bubble in the slot when fetch delivered nothing
   assign exInst = instValid ? inst : instU'(NOP_INST);
   assign rs1    = exInst.rType.rs1;
   assign rs2    = exInst.rType.rs2;

   decoder i_decoder (
      .inst (exInst),
      .ctrl (ctrl),
      .imm  (imm)
   );

   regFile i_regFile (
      .clk (clk),
      .we  (wbWrite),
      .wa  (wbReg.rd),
      .ra1 (rs1),
      .ra2 (rs2),
      .wd  (wbValue),
      .rd1 (rf1),
      .rd2 (rf2)
   );

   // Forward the writeback value, load data included
   assign rs1Val = (wbWrite && wbReg.rd != 5'd0 && wbReg.rd == rs1) ? wbValue : rf1;
   assign rs2Val = (wbWrite && wbReg.rd != 5'd0 && wbReg.rd == rs2) ? wbValue : rf2;

   always_comb
   begin
      case (ctrl.aSel)
         A_PC:    opA = instPc;
         A_ZERO:  opA = 32'd0;
         default: opA = rs1Val;
      endcase
   end

   assign opB = ctrl.useImm ? imm : rs2Val;

   alu i_alu (
      .a           (opA),
      .b           (opB),
      .aluOp       (ctrl.aluOp),
      .funct3      (exInst.bType.funct3),
      .result      (aluResult),
      .branchTaken (branchTaken)
   );

   assign redirect   = ctrl.isJal || ctrl.isJalr || (ctrl.isBranch && branchTaken);
   assign redirectPc = ctrl.isJalr ? {aluResult[31:1], 1'b0} : instPc + imm;

   always_comb
   begin
      dataReq.req   = ctrl.isLoad || ctrl.isStore;
      dataReq.we    = ctrl.isStore;
      dataReq.addr  = aluResult[ADDR_W+1:2];
      dataReq.wdata = rs2Val;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wbReg.valid <= 1'b0;
         wbReg.regWrite <= 1'b0;
      end
      else
      begin
         wbReg.valid <= instValid;
         // A load only returns data if the port was granted
         wbReg.regWrite <= ctrl.regWrite && (!ctrl.isLoad || dataGnt);
      end
      wbReg.rd <= exInst.rType.rd;
      wbReg.wbSel <= ctrl.wbSel;
      wbReg.aluResult <= aluResult;
      wbReg.linkPc <= instPc + 32'd4;
   end

   always_comb
   begin
      case (wbReg.wbSel)
         WB_MEM:  wbValue = rdata;
         WB_PC4:  wbValue = wbReg.linkPc;
         default: wbValue = wbReg.aluResult;
      endcase
   end

   assign wbWrite = wbReg.valid && wbReg.regWrite;

endmodule

// ==== fetchUnit.sv ====
/*
 * Fetch stage: PC sequencing and instruction requests to the shared memory
 */
`timescale 1ns/100ps

module fetchUnit import rvIsaPkg::*, coreCfgPkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        run,
   input  logic        redirect,
   input  logic [31:0] redirectPc,
   input  logic        fetchGnt,
   input  logic [31:0] rdata,
   output memReqS      fetchReq,
   output logic        instValid,
   output instU        inst,
   output logic [31:0] instPc
);

   logic [31:0] pc;
   logic        inFlight;
   logic [31:0] inFlightPc;

   always_comb
   begin
      fetchReq.req   = run;
      fetchReq.we    = 1'b0;
      fetchReq.addr  = pc[ADDR_W+1:2];
      fetchReq.wdata = 32'd0;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= 32'd0;
         inFlight <= 1'b0;
      end
      else if (redirect)
      begin
         // Word fetched this cycle is on the wrong path
         pc <= redirectPc;
         inFlight <= 1'b0;
      end
      else if (!run && inFlight)
      begin
         // Word arrives while stopped, so fetch it again later
         pc <= inFlightPc;
         inFlight <= 1'b0;
      end
      else
      begin
         if (fetchGnt)
            pc <= pc + 32'd4;
         inFlight <= fetchGnt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetchGnt)
         inFlightPc <= pc;
   end

   assign instValid = inFlight && run;
   assign inst      = rdata;
   assign instPc    = inFlightPc;

endmodule

// ==== alu.sv ====
/*
 * Integer ALU with the branch comparator
 */
`timescale 1ns/100ps

module alu import rvIsaPkg::*; (
   input  logic [31:0] a,
   input  logic [31:0] b,
   input  aluOpE       aluOp,
   input  logic [2:0]  funct3,
   output logic [31:0] result,
   output logic        branchTaken
);

   always_comb
   begin
      case (aluOp)
         ALU_ADD:   result = a + b;
         ALU_SUB:   result = a - b;
         ALU_SLL:   result = a << b[4:0];
         ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
         ALU_SLTU:  result = {31'd0, a < b};
         ALU_XOR:   result = a ^ b;
         ALU_SRL:   result = a >> b[4:0];
         ALU_SRA:   result = $unsigned($signed(a) >>> b[4:0]);
         ALU_OR:    result = a | b;
         ALU_AND:   result = a & b;
         ALU_PASSB: result = b;
         default:   result = 32'd0;
      endcase
   end

   // Only meaningful for branch opcodes
   always_comb
   begin
      case (funct3)
         F3_BEQ:  branchTaken = (a == b);
         F3_BNE:  branchTaken = (a != b);
         F3_BLT:  branchTaken = ($signed(a) < $signed(b));
         F3_BGE:  branchTaken = ($signed(a) >= $signed(b));
         F3_BLTU: branchTaken = (a < b);
         F3_BGEU: branchTaken = (a >= b);
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

// ==== decoder.sv ====
/*
 * Instruction decoder: builds the control record and the sign-extended
 * immediate from the format view picked by the opcode
 */
`timescale 1ns/100ps

module decoder import rvIsaPkg::*, coreCfgPkg::*; (
   input  instU        inst,
   output ctrlS        ctrl,
   output logic [31:0] imm
);

   function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt,
                                          input logic isReg);
      aluOpE op;
      case (f3)
         F3_ADD:  op = (isReg && alt) ? ALU_SUB : ALU_ADD;
         F3_SLL:  op = ALU_SLL;
         F3_SLT:  op = ALU_SLT;
         F3_SLTU: op = ALU_SLTU;
         F3_XOR:  op = ALU_XOR;
         F3_SRL:  op = alt ? ALU_SRA : ALU_SRL;
         F3_OR:   op = ALU_OR;
         F3_AND:  op = ALU_AND;
         default: op = ALU_ADD;
      endcase
      return op;
   endfunction

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       alt;

   assign opcode = inst.rType.opcode;
   assign funct3 = inst.rType.funct3;
   assign alt    = inst.rType.funct7[5];

   always_comb
   begin
      // Anything not matched below stays a NOP
      ctrl = '{aluOp: ALU_ADD, aSel: A_REG, wbSel: WB_ALU, default: 1'b0};
      imm  = 32'd0;
      case (opcode)
         OP_LUI:
         begin
            imm = {inst.uType.imm, 12'd0};
            ctrl.aluOp = ALU_PASSB;
            ctrl.aSel = A_ZERO;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_AUIPC:
         begin
            imm = {inst.uType.imm, 12'd0};
            ctrl.aSel = A_PC;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_JAL:
         begin
            imm = {{11{inst.jType.imm20}}, inst.jType.imm20, inst.jType.immHi,
                   inst.jType.imm11, inst.jType.immLo, 1'b0};
            ctrl.isJal = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel = WB_PC4;
         end
         OP_JALR:
         begin
            imm = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            ctrl.isJalr = 1'b1;
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.wbSel = WB_PC4;
         end
         OP_BRANCH:
         begin
            imm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                   inst.bType.immHi, inst.bType.immLo, 1'b0};
            ctrl.aluOp = ALU_SUB;
            ctrl.isBranch = 1'b1;
         end
         OP_LOAD:
         begin
            imm = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            ctrl.useImm = 1'b1;
            ctrl.isLoad = (funct3 == F3_W);
            ctrl.regWrite = (funct3 == F3_W);
            ctrl.wbSel = WB_MEM;
         end
         OP_STORE:
         begin
            imm = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
            ctrl.useImm = 1'b1;
            ctrl.isStore = (funct3 == F3_W);
         end
         OP_IMM:
         begin
            imm = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            ctrl.aluOp = aluFromFunct(funct3, alt, 1'b0);
            ctrl.useImm = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_REG:
         begin
            ctrl.aluOp = aluFromFunct(funct3, alt, 1'b1);
            ctrl.regWrite = 1'b1;
         end
         default:
         begin
            ctrl.regWrite = 1'b0;
         end
      endcase
   end

endmodule

// ==== regFile.sv ====
/*
 * Integer register file, 32 x 32 bits, two read ports and one write port
 */
`timescale 1ns/100ps

module regFile (
   input  logic        clk,
   input  logic        we,
   input  logic [4:0]  wa,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   // x0 reads as zero whatever the array holds
   assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// ==== coreCfgPkg.sv ====
/*
 * Core configuration: shared memory geometry, memory request format
 * and the pipeline control and writeback records
 */
package coreCfgPkg;

   localparam int MEM_WORDS = 1024;
   localparam int ADDR_W    = 10;

   // Operand A sources
   localparam logic [1:0] A_REG  = 2'd0;
   localparam logic [1:0] A_PC   = 2'd1;
   localparam logic [1:0] A_ZERO = 2'd2;

   // Writeback sources
   localparam logic [1:0] WB_ALU = 2'd0;
   localparam logic [1:0] WB_MEM = 2'd1;
   localparam logic [1:0] WB_PC4 = 2'd2;

   typedef struct packed {
      logic              req;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [31:0]       wdata;
   } memReqS;

   typedef struct packed {
      rvIsaPkg::aluOpE aluOp;
      logic            useImm;
      logic [1:0]      aSel;
      logic            regWrite;
      logic [1:0]      wbSel;
      logic            isBranch;
      logic            isJal;
      logic            isJalr;
      logic            isLoad;
      logic            isStore;
   } ctrlS;

   typedef struct packed {
      logic        valid;
      logic        regWrite;
      logic [4:0]  rd;
      logic [1:0]  wbSel;
      logic [31:0] aluResult;
      logic [31:0] linkPc;
   } wbRegS;

endpackage

// ==== rvIsaPkg.sv ====
/*
 * RV32I instruction set definitions: opcodes, function codes, ALU
 * operations and the format views of one instruction word
 */
package rvIsaPkg;

   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_AUIPC  = 7'b0010111;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_JALR   = 7'b1100111;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_LOAD   = 7'b0000011;
   localparam logic [6:0] OP_STORE  = 7'b0100011;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;

   // ALU function codes
   localparam logic [2:0] F3_ADD  = 3'd0;
   localparam logic [2:0] F3_SLL  = 3'd1;
   localparam logic [2:0] F3_SLT  = 3'd2;
   localparam logic [2:0] F3_SLTU = 3'd3;
   localparam logic [2:0] F3_XOR  = 3'd4;
   localparam logic [2:0] F3_SRL  = 3'd5;
   localparam logic [2:0] F3_OR   = 3'd6;
   localparam logic [2:0] F3_AND  = 3'd7;

   // Word access is the only load/store width kept
   localparam logic [2:0] F3_W = 3'd2;

   // Branch conditions
   localparam logic [2:0] F3_BEQ  = 3'd0;
   localparam logic [2:0] F3_BNE  = 3'd1;
   localparam logic [2:0] F3_BLT  = 3'd4;
   localparam logic [2:0] F3_BGE  = 3'd5;
   localparam logic [2:0] F3_BLTU = 3'd6;
   localparam logic [2:0] F3_BGEU = 3'd7;

   // ADDI x0,x0,0
   localparam logic [31:0] NOP_INST = 32'h0000_0013;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASSB
   } aluOpE;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rTypeS;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } iTypeS;

   typedef struct packed {
      logic [6:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] immLo;
      logic [6:0] opcode;
   } sTypeS;

   // Branch offset bits are scattered, bit 0 is implied
   typedef struct packed {
      logic       imm12;
      logic [5:0] immHi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] immLo;
      logic       imm11;
      logic [6:0] opcode;
   } bTypeS;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } uTypeS;

   typedef struct packed {
      logic       imm20;
      logic [9:0] immLo;
      logic       imm11;
      logic [7:0] immHi;
      logic [4:0] rd;
      logic [6:0] opcode;
   } jTypeS;

   typedef union packed {
      rTypeS rType;
      iTypeS iType;
      sTypeS sType;
      bTypeS bType;
      uTypeS uType;
      jTypeS jType;
   } instU;

endpackage
